//--- design/lc3b_cache_pkg.sv
`default_nettype none

package lc3b_cache_pkg;

	// address split of the lc3b byte address
	localparam int word_bits = 16;
	localparam int tag_bits = 9;
	localparam int set_bits = 3;
	localparam int offset_bits = 4;
	localparam int num_sets = 1 << set_bits;
	localparam int line_bits = 8 << offset_bits;

	typedef logic [word_bits-1:0] lc3b_word;
	typedef logic [tag_bits-1:0] lc3b_c_tag;
	typedef logic [set_bits-1:0] lc3b_c_set;
	typedef logic [offset_bits-1:0] lc3b_c_offset;
	typedef logic [line_bits-1:0] lc3b_c_block;
	typedef logic [1:0] lc3b_mem_wmask;

	// processor side wishbone
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		lc3b_word address;
		lc3b_word wdata;
		lc3b_mem_wmask sel;
	} cpu_req_t;

	typedef struct packed {
		logic ack;
		lc3b_word rdata;
	} cpu_rsp_t;

	// memory side, whole lines only
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		lc3b_word address;
		lc3b_c_block wdata;
	} pmem_req_t;

	typedef struct packed {
		logic ack;
		lc3b_c_block rdata;
	} pmem_rsp_t;

	typedef enum logic [1:0] {idle, compare, write_back, allocate} cache_state_t;

	// fill_sel picks the memory line over the merged store line
	typedef struct packed {
		logic ld_data;
		logic ld_tag;
		logic ld_valid;
		logic ld_dirty;
		logic dirty_in;
		logic fill_sel;
	} way_ctrl_t;

endpackage

`default_nettype wire

//--- design/set_array.sv
`timescale 1ns/1ns
`default_nettype none

module set_array
	import lc3b_cache_pkg::*;
#(
	parameter int width = 1
)
(
	input wire logic clk,
	input wire logic rst,
	input wire logic write,
	input wire lc3b_c_set index,
	input wire logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entries [num_sets];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < num_sets; i++)
				entries[i] <= '0;
		end
		else if (write)
			entries[index] <= datain;
	end

	// read port is combinational
	assign dataout = entries[index];

endmodule : set_array

`default_nettype wire

//--- design/line_update.sv
`timescale 1ns/1ns
`default_nettype none

module line_update
	import lc3b_cache_pkg::*;
(
	input wire lc3b_c_block line,
	input wire lc3b_c_offset offset,
	input wire lc3b_word wdata,
	input wire lc3b_mem_wmask sel,
	output lc3b_c_block merged,
	output lc3b_word word
);

	// bit position of the addressed word, offset[0] ignored
	logic [6:0] base;

	assign base = {offset[3:1], 4'b0000};

	always_comb
	begin
		merged = line;
		if (sel[0])
			merged[base +: 8] = wdata[7:0];
		if (sel[1])
			merged[base + 7'd8 +: 8] = wdata[15:8];
	end

	assign word = line[base +: 16];

endmodule : line_update

`default_nettype wire

//--- design/cache_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module cache_datapath
	import lc3b_cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire lc3b_word cpu_addr,
	input wire lc3b_word cpu_wdata,
	input wire lc3b_mem_wmask cpu_sel,
	input wire lc3b_c_block pmem_line,
	input wire way_ctrl_t way1_ctrl,
	input wire way_ctrl_t way2_ctrl,
	input wire logic ld_lru,
	input wire logic data_sel,
	input wire logic [1:0] addr_sel,
	output logic hit,
	output logic hit_way,
	output logic lru_way,
	output logic victim_valid,
	output logic victim_dirty,
	output lc3b_word rdata,
	output lc3b_word pmem_addr,
	output lc3b_c_block victim_line
);

	lc3b_c_tag req_tag;
	lc3b_c_set req_set;
	lc3b_c_offset req_offset;

	way_ctrl_t ctrl [2];
	lc3b_c_block way_line [2];
	lc3b_c_block fill_line [2];
	lc3b_c_tag way_tag [2];
	logic way_valid [2];
	logic way_dirty [2];
	logic way_hit [2];
	logic lru;

	lc3b_c_block sel_line;
	lc3b_c_block merged_line;

	assign req_offset = cpu_addr[offset_bits-1:0];
	assign req_set = cpu_addr[offset_bits +: set_bits];
	assign req_tag = cpu_addr[word_bits-1 -: tag_bits];

	assign ctrl[0] = way1_ctrl;
	assign ctrl[1] = way2_ctrl;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		// store merge or memory fill
		assign fill_line[w] = ctrl[w].fill_sel ? pmem_line : merged_line;

		set_array #(.width(line_bits)) data_array (
			.clk, .rst, .write(ctrl[w].ld_data), .index(req_set),
			.datain(fill_line[w]), .dataout(way_line[w])
		);
		set_array #(.width(tag_bits)) tag_array (
			.clk, .rst, .write(ctrl[w].ld_tag), .index(req_set),
			.datain(req_tag), .dataout(way_tag[w])
		);
		set_array #(.width(1)) valid_array (
			.clk, .rst, .write(ctrl[w].ld_valid), .index(req_set),
			.datain(1'b1), .dataout(way_valid[w])
		);
		set_array #(.width(1)) dirty_array (
			.clk, .rst, .write(ctrl[w].ld_dirty), .index(req_set),
			.datain(ctrl[w].dirty_in), .dataout(way_dirty[w])
		);

		assign way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
	end

	// lru points at the way not used by this hit
	set_array #(.width(1)) lru_array (
		.clk, .rst, .write(ld_lru), .index(req_set),
		.datain(~hit_way), .dataout(lru)
	);

	assign hit = way_hit[0] || way_hit[1];
	assign hit_way = way_hit[1];

	// invalid ways go first, way 1 before way 2
	always_comb
	begin
		if (!way_valid[0])
			lru_way = 1'b0;
		else if (!way_valid[1])
			lru_way = 1'b1;
		else
			lru_way = lru;
	end

	assign victim_valid = way_valid[lru_way];
	assign victim_dirty = way_dirty[lru_way];

	assign sel_line = data_sel ? way_line[1] : way_line[0];
	assign victim_line = sel_line;

	line_update update (
		.line(sel_line),
		.offset(req_offset),
		.wdata(cpu_wdata),
		.sel(cpu_sel),
		.merged(merged_line),
		.word(rdata)
	);

	always_comb
	begin
		case (addr_sel)
			2'd1: pmem_addr = {way_tag[0], req_set, {offset_bits{1'b0}}};
			2'd2: pmem_addr = {way_tag[1], req_set, {offset_bits{1'b0}}};
			default: pmem_addr = {req_tag, req_set, {offset_bits{1'b0}}};
		endcase
	end

endmodule : cache_datapath

`default_nettype wire

//--- design/cache_control.sv
`timescale 1ns/1ns
`default_nettype none

module cache_control
	import lc3b_cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire cpu_req_t cpu_req,
	output logic cpu_ack,
	output logic pmem_cyc,
	output logic pmem_stb,
	output logic pmem_we,
	input wire logic pmem_ack,
	input wire logic hit,
	input wire logic hit_way,
	input wire logic lru_way,
	input wire logic victim_valid,
	input wire logic victim_dirty,
	output way_ctrl_t way1_ctrl,
	output way_ctrl_t way2_ctrl,
	output logic ld_lru,
	output logic data_sel,
	output logic [1:0] addr_sel
);

	cache_state_t state;
	cache_state_t next_state;

	// load strobes for the one way being touched
	way_ctrl_t upd;
	logic upd_way;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		cpu_ack = 1'b0;
		pmem_cyc = 1'b0;
		pmem_stb = 1'b0;
		pmem_we = 1'b0;
		ld_lru = 1'b0;
		data_sel = lru_way;
		addr_sel = 2'd0;
		upd = '0;
		upd_way = lru_way;

		case (state)
			idle:
			begin
				if (cpu_req.cyc && cpu_req.stb)
					next_state = compare;
			end
			compare:
			begin
				if (!(cpu_req.cyc && cpu_req.stb))
					next_state = idle;
				else if (hit)
				begin
					cpu_ack = 1'b1;
					ld_lru = 1'b1;
					data_sel = hit_way;
					upd_way = hit_way;
					if (cpu_req.we)
					begin
						upd.ld_data = 1'b1;
						upd.ld_dirty = 1'b1;
						upd.dirty_in = 1'b1;
					end
					next_state = idle;
				end
				else if (victim_valid && victim_dirty)
					next_state = write_back;
				else
					next_state = allocate;
			end
			write_back:
			begin
				pmem_cyc = 1'b1;
				pmem_stb = 1'b1;
				pmem_we = 1'b1;
				addr_sel = lru_way ? 2'd2 : 2'd1;
				if (pmem_ack)
					next_state = allocate;
			end
			allocate:
			begin
				pmem_cyc = 1'b1;
				pmem_stb = 1'b1;
				// fetched line lands clean
				if (pmem_ack)
				begin
					upd.ld_data = 1'b1;
					upd.ld_tag = 1'b1;
					upd.ld_valid = 1'b1;
					upd.ld_dirty = 1'b1;
					upd.fill_sel = 1'b1;
					next_state = compare;
				end
			end
			default: next_state = idle;
		endcase
	end

	always_comb
	begin
		way1_ctrl = '0;
		way2_ctrl = '0;
		if (upd_way)
			way2_ctrl = upd;
		else
			way1_ctrl = upd;
	end

endmodule : cache_control

`default_nettype wire

//--- design/lc3b_cache.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_cache
	import lc3b_cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output pmem_req_t pmem_req,
	input wire pmem_rsp_t pmem_rsp
);

	way_ctrl_t way1_ctrl;
	way_ctrl_t way2_ctrl;
	logic ld_lru;
	logic data_sel;
	logic [1:0] addr_sel;
	logic hit;
	logic hit_way;
	logic lru_way;
	logic victim_valid;
	logic victim_dirty;

	cache_control control (
		.clk,
		.rst,
		.cpu_req,
		.cpu_ack(cpu_rsp.ack),
		.pmem_cyc(pmem_req.cyc),
		.pmem_stb(pmem_req.stb),
		.pmem_we(pmem_req.we),
		.pmem_ack(pmem_rsp.ack),
		.hit,
		.hit_way,
		.lru_way,
		.victim_valid,
		.victim_dirty,
		.way1_ctrl,
		.way2_ctrl,
		.ld_lru,
		.data_sel,
		.addr_sel
	);

	cache_datapath datapath (
		.clk,
		.rst,
		.cpu_addr(cpu_req.address),
		.cpu_wdata(cpu_req.wdata),
		.cpu_sel(cpu_req.sel),
		.pmem_line(pmem_rsp.rdata),
		.way1_ctrl,
		.way2_ctrl,
		.ld_lru,
		.data_sel,
		.addr_sel,
		.hit,
		.hit_way,
		.lru_way,
		.victim_valid,
		.victim_dirty,
		.rdata(cpu_rsp.rdata),
		.pmem_addr(pmem_req.address),
		.victim_line(pmem_req.wdata)
	);

endmodule : lc3b_cache

`default_nettype wire

//--- bench/pmem_model.sv
`timescale 1ns/1ns
`default_nettype none

module pmem_model
	import lc3b_cache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire pmem_req_t req,
	output pmem_rsp_t rsp,
	output logic [15:0] write_count,
	output logic [15:0] read_count
);

	lc3b_c_block mem [4096];
	logic ack_q = 1'b0;
	lc3b_c_block rdata_q = '0;
	logic [1:0] wait_cnt;
	logic [11:0] line_idx;

	// every word holds its own byte address, scrambled
	function automatic lc3b_c_block pattern_line(input logic [11:0] idx);
		lc3b_c_block result;
		logic [2:0] w;
		for (int i = 0; i < 8; i++)
		begin
			w = 3'(i);
			result[16*i +: 16] = {idx, w, 1'b0} ^ 16'h5a3c;
		end
		return result;
	endfunction

	initial
	begin
		for (int i = 0; i < 4096; i++)
			mem[i] = pattern_line(12'(i));
	end

	assign line_idx = req.address[15:4];
	assign rsp.ack = ack_q;
	assign rsp.rdata = rdata_q;

	// two wait cycles, then a single cycle ack
	always @(posedge clk)
	begin
		if (rst)
		begin
			ack_q <= 1'b0;
			wait_cnt <= 2'd0;
			write_count <= '0;
			read_count <= '0;
		end
		else if (ack_q)
		begin
			ack_q <= 1'b0;
			wait_cnt <= 2'd0;
		end
		else if (req.cyc && req.stb)
		begin
			if (wait_cnt == 2'd2)
			begin
				ack_q <= 1'b1;
				if (req.we)
				begin
					mem[line_idx] <= req.wdata;
					write_count <= write_count + 16'd1;
				end
				else
				begin
					rdata_q <= mem[line_idx];
					read_count <= read_count + 16'd1;
				end
			end
			else
				wait_cnt <= wait_cnt + 2'd1;
		end
	end

endmodule : pmem_model

`default_nettype wire

//--- bench/lc3b_cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_cache_tb
	import lc3b_cache_pkg::*;
();

	typedef struct packed {
		logic is_write;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask sel;
		lc3b_word exp_rdata;
		logic [15:0] exp_writes;
		logic [15:0] exp_reads;
	} txn_t;

	localparam string input_file = "bench/cache_input.txt";

	logic clk;
	logic rst;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	pmem_req_t pmem_req;
	pmem_rsp_t pmem_rsp;
	logic [15:0] write_count;
	logic [15:0] read_count;

	txn_t txns[$];
	logic loaded;
	int errors = 0;
	int passed = 0;
	int failed = 0;

	lc3b_cache lc3b_cache_i (
		.clk,
		.rst,
		.cpu_req,
		.cpu_rsp,
		.pmem_req,
		.pmem_rsp
	);

	pmem_model pmem (
		.clk,
		.rst,
		.req(pmem_req),
		.rsp(pmem_rsp),
		.write_count,
		.read_count
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic load_transactions();
		int fd;
		int code;
		string text;
		logic [7:0] op;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask sel;
		lc3b_word exp_rdata;
		logic [15:0] exp_w;
		logic [15:0] exp_r;
		txn_t t;
		fd = $fopen(input_file, "r");
		if (fd == 0)
		begin
			$display("cannot open %s", input_file);
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			code = $fgets(text, fd);
			if (code == 0)
				break;
			code = $sscanf(text, "%c %h %h %h %h %h %h", op, addr, wdata, sel,
				exp_rdata, exp_w, exp_r);
			// comment and blank lines never give a full record
			if (code == 7)
			begin
				t.is_write = (op == "w");
				t.addr = addr;
				t.wdata = wdata;
				t.sel = sel;
				t.exp_rdata = exp_rdata;
				t.exp_writes = exp_w;
				t.exp_reads = exp_r;
				txns.push_back(t);
			end
		end
		$fclose(fd);
		if (txns.size() == 0)
		begin
			$display("no transactions found in %s", input_file);
			errors++;
		end
	endtask

	// one wishbone transfer and its checks against the file
	task automatic run_transfer(input int idx, input txn_t t);
		lc3b_word got;
		logic ok;
		@(posedge clk);
		cpu_req.cyc <= 1'b1;
		cpu_req.stb <= 1'b1;
		cpu_req.we <= t.is_write;
		cpu_req.address <= t.addr;
		cpu_req.wdata <= t.wdata;
		cpu_req.sel <= t.sel;
		@(posedge clk);
		while (!cpu_rsp.ack)
			@(posedge clk);
		got = cpu_rsp.rdata;
		cpu_req.cyc <= 1'b0;
		cpu_req.stb <= 1'b0;
		cpu_req.we <= 1'b0;
		ok = 1'b1;
		if (!t.is_write && got !== t.exp_rdata)
		begin
			$display("** Error: cpu_rsp.rdata = %h, expected %h", got, t.exp_rdata);
			ok = 1'b0;
		end
		if (write_count !== t.exp_writes)
		begin
			$display("** Error: write_count = %h, expected %h", write_count, t.exp_writes);
			ok = 1'b0;
		end
		if (read_count !== t.exp_reads)
		begin
			$display("** Error: read_count = %h, expected %h", read_count, t.exp_reads);
			ok = 1'b0;
		end
		if (ok)
			passed++;
		else
		begin
			failed++;
			errors++;
		end
		$display("test %0d: %s addr %h sel %b: %s", idx + 1,
			t.is_write ? "write" : "read", t.addr, t.sel, ok ? "ok" : "mismatch");
	endtask

	initial
	begin
		cpu_req = '0;
		rst = 1'b1;
		loaded = 1'b0;
		load_transactions();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		foreach (txns[i])
			run_transfer(i, txns[i]);
		@(posedge clk);
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			txns.size(), passed, failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// 200 cycles per transaction plus one share for reset
	initial
	begin
		int limit;
		wait (loaded);
		limit = (txns.size() + 1) * 200;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles without finishing", limit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule : lc3b_cache_tb

`default_nettype wire

//--- bench/cache_input.txt
# op addr wdata sel rdata writebacks fills, all hex; op r reads, op w writes
# rdata is checked on reads only, both counts are totals since reset
r 0102 0000 3 5b3e 0 1
r 0104 0000 3 5b38 0 1
w 0104 a7c1 1 0000 0 1
r 0104 0000 3 5bc1 0 1
w 0106 9e42 2 0000 0 1
r 0106 0000 3 9e3a 0 1
r 0888 0000 3 52b4 0 2
r 0102 0000 3 5b3e 0 2
r 088a 0000 3 52b6 0 2
r 1000 0000 3 4a3c 1 3
r 2004 0000 3 7a38 1 4
r 0104 0000 3 5bc1 1 5
r 0106 0000 3 9e3a 1 5
r 0102 0000 3 5b3e 1 5
w 0a5e 1234 3 0000 1 6
r 0a5e 0000 3 1234 1 6
r 0a50 0000 3 506c 1 6
r 3a5e 0000 3 6062 1 7
r 7a52 0000 3 206e 2 8
r 0a5e 0000 3 1234 2 9

//--- lc3b_cache.f
design/lc3b_cache_pkg.sv
design/set_array.sv
design/line_update.sv
design/cache_datapath.sv
design/cache_control.sv
design/lc3b_cache.sv
bench/pmem_model.sv
bench/lc3b_cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= lc3b_cache_tb
FILELIST ?= lc3b_cache.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -j 0 --timescale 1ns/1ns
PASS_MSG ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
